/* compile.f */
+incdir+hw
hw/rv_decode_pkg.sv
hw/rv_decode_ifs.sv
hw/field_decoder.sv
hw/imm_generator.sv
hw/decode_merge.sv
hw/rv_decode_top.sv
tb/tb_rv_decode.sv

/* hw/decode_merge.sv */
// Output stage with a single-beat Wishbone classic slave; every cycle acks, no error or retry
`include "rv_macros.svh"

module decode_merge (
    input  logic                      clock,
    input  logic                      rst_n,
    dec_fields_if.consumer            fields,
    imm_set_if.consumer               imms,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    output logic [`RV_XLEN-1:0]       wb_dat_o,
    output logic                      wb_ack,
    output rv_decode_pkg::rv_class_e  op_class,
    output rv_decode_pkg::rv_format_e format,
    output logic [4:0]                rd,
    output logic [4:0]                rs1,
    output logic [4:0]                rs2,
    output logic [4:0]                shamt,
    output logic [2:0]                funct3,
    output logic [6:0]                funct7,
    output logic [`RV_XLEN-1:0]       imm,
    output logic                      rd_we,
    output logic                      illegal,
    output logic                      decoded_valid
);
    import rv_decode_pkg::*;

    logic                accept;
    logic [`RV_XLEN-1:0] imm_next;
    logic [2:0]          funct3_next;
    logic [6:0]          funct7_next;

    // Ack low gates a new request so each transfer is seen once
    assign accept = wb_cyc && wb_stb && !wb_ack;

    // Illegal words arrive as FMT_NONE and take the zero branch
    always_comb
    begin
        case (fields.format)
            FMT_I:
                imm_next = fields.is_shift ? {{(`RV_XLEN-5){1'b0}}, imms.shamt} : imms.imm_i;
            FMT_S:   imm_next = imms.imm_s;
            FMT_B:   imm_next = imms.imm_b;
            FMT_U:   imm_next = imms.imm_u;
            FMT_J:   imm_next = imms.imm_j;
            default: imm_next = '0;
        endcase
    end

    assign funct3_next = (fields.illegal || (fields.format == FMT_U) || (fields.format == FMT_J))
                         ? 3'd0 : fields.funct3;
    assign funct7_next = ((fields.format == FMT_R) || fields.is_shift) ? fields.funct7 : 7'd0;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            wb_ack        <= 1'b0;
            decoded_valid <= 1'b0;
            op_class      <= rv_class_e'(4'd0);
            format        <= rv_format_e'(3'd0);
            rd            <= 5'd0;
            rs1           <= 5'd0;
            rs2           <= 5'd0;
            shamt         <= 5'd0;
            funct3        <= 3'd0;
            funct7        <= 7'd0;
            imm           <= '0;
            rd_we         <= 1'b0;
            illegal       <= 1'b0;
        end
        else
        begin
            wb_ack <= accept;
            // Reads only ack and leave the decode registers as they are
            if (accept && wb_we)
            begin
                decoded_valid <= 1'b1;
                op_class      <= fields.op_class;
                format        <= fields.format;
                rd            <= fields.rd_we ? fields.rd : 5'd0;
                rs1           <= fields.uses_rs1 ? fields.rs1 : 5'd0;
                rs2           <= fields.uses_rs2 ? fields.rs2 : 5'd0;
                shamt         <= fields.is_shift ? imms.shamt : 5'd0;
                funct3        <= funct3_next;
                funct7        <= funct7_next;
                imm           <= imm_next;
                rd_we         <= fields.rd_we;
                illegal       <= fields.illegal;
            end
        end
    end

    // Read data is the held immediate
    assign wb_dat_o = imm;

endmodule

/* hw/field_decoder.sv */
// Combinational RV32I classifier; FENCE and SYSTEM pass with any funct3 and stay undecoded
`include "rv_macros.svh"

module field_decoder (
    input rv_decode_pkg::rv_instr_u instr,
    dec_fields_if.producer          fields
);
    import rv_decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    rv_class_e  cls;
    rv_format_e fmt;
    rv_format_e fmt_out;
    logic       legal;
    logic       no_regs;
    logic       uses_rd;
    logic       uses_rs1;
    logic       uses_rs2;

    assign opcode = instr.r_view.opcode;
    assign f3     = instr.r_view.funct3;
    assign f7     = instr.r_view.funct7;

    // Opcode to class and format under the funct3 and funct7 legality rules
    // All listed opcodes end in 11, so compressed words fall to the default branch
    always_comb
    begin
        cls   = CLS_ILLEGAL;
        fmt   = FMT_NONE;
        legal = 1'b0;
        case (opcode)
            `RV_OP_LUI:
            begin
                cls   = CLS_LUI;
                fmt   = FMT_U;
                legal = 1'b1;
            end
            `RV_OP_AUIPC:
            begin
                cls   = CLS_AUIPC;
                fmt   = FMT_U;
                legal = 1'b1;
            end
            `RV_OP_JAL:
            begin
                cls   = CLS_JAL;
                fmt   = FMT_J;
                legal = 1'b1;
            end
            `RV_OP_JALR:
            begin
                cls   = CLS_JALR;
                fmt   = FMT_I;
                legal = (f3 == 3'b000);
            end
            `RV_OP_BRANCH:
            begin
                cls   = CLS_BRANCH;
                fmt   = FMT_B;
                legal = (f3 != 3'b010) && (f3 != 3'b011);
            end
            `RV_OP_LOAD:
            begin
                cls   = CLS_LOAD;
                fmt   = FMT_I;
                legal = f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
            end
            `RV_OP_STORE:
            begin
                cls   = CLS_STORE;
                fmt   = FMT_S;
                legal = (f3 <= 3'b010);
            end
            `RV_OP_IMM:
            begin
                cls = CLS_OP_IMM;
                fmt = FMT_I;
                // Shifts keep funct7 in the upper immediate bits
                case (f3)
                    3'b001:  legal = (f7 == 7'b0000000);
                    3'b101:  legal = (f7 == 7'b0000000) || (f7 == 7'b0100000);
                    default: legal = 1'b1;
                endcase
            end
            `RV_OP_OP:
            begin
                cls   = CLS_OP;
                fmt   = FMT_R;
                legal = (f7 == 7'b0000000) ||
                        ((f7 == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101)));
            end
            `RV_OP_FENCE:
            begin
                cls   = CLS_FENCE;
                fmt   = FMT_I;
                legal = 1'b1;
            end
            `RV_OP_SYSTEM:
            begin
                cls   = CLS_SYSTEM;
                fmt   = FMT_I;
                legal = 1'b1;
            end
            default:
                legal = 1'b0;
        endcase
    end

    assign fmt_out = legal ? fmt : FMT_NONE;
    assign no_regs = (cls == CLS_FENCE) || (cls == CLS_SYSTEM);

    // Register usage follows the format
    always_comb
    begin
        uses_rd  = 1'b0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (fmt_out)
            FMT_R:
            begin
                uses_rd  = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            FMT_I:
            begin
                uses_rd  = !no_regs;
                uses_rs1 = !no_regs;
            end
            FMT_S, FMT_B:
            begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            FMT_U, FMT_J:
                uses_rd = 1'b1;
            default:
                uses_rd = 1'b0;
        endcase
    end

    assign fields.format   = fmt_out;
    assign fields.op_class = legal ? cls : CLS_ILLEGAL;
    assign fields.rd       = instr.r_view.rd;
    assign fields.rs1      = instr.r_view.rs1;
    assign fields.rs2      = instr.r_view.rs2;
    assign fields.funct3   = f3;
    assign fields.funct7   = f7;
    // Writes to x0 are discarded
    assign fields.rd_we    = uses_rd && (instr.r_view.rd != 5'd0);
    assign fields.uses_rs1 = uses_rs1;
    assign fields.uses_rs2 = uses_rs2;
    assign fields.is_shift = legal && (cls == CLS_OP_IMM) && (f3[1:0] == 2'b01);
    assign fields.illegal  = !legal;

endmodule

/* hw/imm_generator.sv */
// Builds all RV32I immediates from any word, legal or not; selection happens downstream
`include "rv_macros.svh"

module imm_generator (
    input rv_decode_pkg::rv_instr_u instr,
    imm_set_if.producer             imms
);

    logic sign;

    assign sign = instr.i_view.imm12[11];

    // I type, bits 31..20
    assign imms.imm_i = {{(`RV_XLEN-12){sign}}, instr.i_view.imm12};

    // S type, bits 31..25 over 11..7
    assign imms.imm_s = {{(`RV_XLEN-12){sign}}, instr.s_view.imm_hi7, instr.s_view.imm_lo5};

    // B type, bit 7 lands in imm[11]
    assign imms.imm_b = {{(`RV_XLEN-12){sign}},
                         instr.s_view.imm_lo5[0],
                         instr.s_view.imm_hi7[5:0],
                         instr.s_view.imm_lo5[4:1],
                         1'b0};

    // U type, low twelve bits cleared
    assign imms.imm_u = {instr.u_view.imm20, 12'b0};

    // J type, imm20 holds bits 31..12 of the word
    assign imms.imm_j = {{(`RV_XLEN-20){sign}},
                         instr.u_view.imm20[7:0],
                         instr.u_view.imm20[8],
                         instr.u_view.imm20[18:9],
                         1'b0};

    // Shift amount sits in the low immediate bits, 24..20
    assign imms.shamt = instr.i_view.imm12[4:0];

endmodule

/* hw/rv_decode_ifs.sv */
// Combinational links from the two parallel decode blocks to the merge stage; no handshake
`include "rv_macros.svh"

// Classification and raw register fields of one word
interface dec_fields_if;
    import rv_decode_pkg::*;

    rv_format_e format;
    rv_class_e  op_class;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       rd_we;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       is_shift;
    logic       illegal;

    modport producer (output format, op_class, rd, rs1, rs2, funct3, funct7,
                      output rd_we, uses_rs1, uses_rs2, is_shift, illegal);
    modport consumer (input format, op_class, rd, rs1, rs2, funct3, funct7,
                      input rd_we, uses_rs1, uses_rs2, is_shift, illegal);
endinterface

// Every immediate format of the same word, already sign-extended
interface imm_set_if;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    logic [4:0]          shamt;

    modport producer (output imm_i, imm_s, imm_b, imm_u, imm_j, shamt);
    modport consumer (input imm_i, imm_s, imm_b, imm_u, imm_j, shamt);
endinterface

/* hw/rv_decode_pkg.sv */
// Instruction views and decode enumerations for 32-bit RV32I words; CSR detail is not decoded
package rv_decode_pkg;

    // R type layout, also the source of the plain register fields
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_view_t;

    // I type layout with the 12-bit immediate on top
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_view_t;

    // S type layout, the B immediate reuses the same two pieces
    typedef struct packed {
        logic [6:0] imm_hi7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo5;
        logic [6:0] opcode;
    } rv_s_view_t;

    // U type layout, the J immediate is scrambled inside imm20
    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_u_view_t;

    // One instruction word, read differently by each decode block
    typedef union packed {
        rv_r_view_t r_view;
        rv_i_view_t i_view;
        rv_s_view_t s_view;
        rv_u_view_t u_view;
    } rv_instr_u;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_NONE
    } rv_format_e;

    typedef enum logic [3:0] {
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_OP_IMM,
        CLS_OP,
        CLS_FENCE,
        CLS_SYSTEM,
        CLS_ILLEGAL
    } rv_class_e;

endpackage

/* hw/rv_decode_top.sv */
// RV32I decode unit behind a Wishbone classic slave; one 32-bit word per write, no bursts
`include "rv_macros.svh"

module rv_decode_top (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`RV_XLEN-1:0]       wb_dat_i,
    output logic [`RV_XLEN-1:0]       wb_dat_o,
    output logic                      wb_ack,
    output rv_decode_pkg::rv_class_e  op_class,
    output rv_decode_pkg::rv_format_e format,
    output logic [4:0]                rd,
    output logic [4:0]                rs1,
    output logic [4:0]                rs2,
    output logic [2:0]                funct3,
    output logic [6:0]                funct7,
    output logic [4:0]                shamt,
    output logic [`RV_XLEN-1:0]       imm,
    output logic                      rd_we,
    output logic                      illegal,
    output logic                      decoded_valid
);
    import rv_decode_pkg::*;

    rv_instr_u instr;

    dec_fields_if fields_if ();
    imm_set_if    imm_if ();

    // Both parallel blocks see the raw bus word
    assign instr = rv_instr_u'(wb_dat_i);

    field_decoder field_decoder_i (
        .instr  (instr),
        .fields (fields_if)
    );

    imm_generator imm_generator_i (
        .instr (instr),
        .imms  (imm_if)
    );

    decode_merge decode_merge_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .fields        (fields_if),
        .imms          (imm_if),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_dat_o      (wb_dat_o),
        .wb_ack        (wb_ack),
        .op_class      (op_class),
        .format        (format),
        .rd            (rd),
        .rs1           (rs1),
        .rs2           (rs2),
        .shamt         (shamt),
        .funct3        (funct3),
        .funct7        (funct7),
        .imm           (imm),
        .rd_we         (rd_we),
        .illegal       (illegal),
        .decoded_valid (decoded_valid)
    );

endmodule

/* hw/rv_macros.svh */
// Word width and major opcodes of RV32I only; compressed and 64-bit encodings are not covered
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Data and instruction word width
`define RV_XLEN 32

// Upper immediate and jump opcodes
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111

// Control flow and memory access
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011

// Integer arithmetic
`define RV_OP_IMM    7'b0010011
`define RV_OP_OP     7'b0110011

// Only classified, their internal fields carry no meaning here
`define RV_OP_FENCE  7'b0001111
`define RV_OP_SYSTEM 7'b1110011

`endif

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in its output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_rv_decode -o sim_rv_decode
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_rv_decode)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "All tests passed!"; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1

/* tb/tb_rv_decode.sv */
// Self-checking testbench for rv_decode_top; needs --timing and replays one fixed LFSR sequence
`include "rv_macros.svh"

module tb_rv_decode;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_decode_pkg::*;

    localparam int IDLE_CYCLES = 10;
    localparam int N_LEGAL     = 300;
    localparam int N_ILLEGAL   = 100;
    localparam int N_SHIFT     = 60;
    localparam int N_READ      = 40;
    localparam int N_B2B       = 50;
    localparam int N_GAP       = 50;
    // Read pairs and gapped writes count for several transactions each
    localparam int TXN_TOTAL   = IDLE_CYCLES + N_LEGAL + N_ILLEGAL + N_SHIFT + 2
                                 + 3 * N_READ + N_B2B + 2 * N_GAP + 1;
    localparam int TIMEOUT_CYCLES = 4 * TXN_TOTAL + 8 + 100;

    logic        clock = 1'b0;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack;
    rv_class_e   op_class;
    rv_format_e  format;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  shamt;
    logic [31:0] imm;
    logic        rd_we;
    logic        illegal;
    logic        decoded_valid;

    // Expected outputs as of the last accepted write
    rv_class_e   exp_class;
    rv_format_e  exp_fmt;
    logic [4:0]  exp_rd;
    logic [4:0]  exp_rs1;
    logic [4:0]  exp_rs2;
    logic [2:0]  exp_f3;
    logic [6:0]  exp_f7;
    logic [4:0]  exp_shamt;
    logic [31:0] exp_imm;
    logic        exp_rd_we;
    logic        exp_illegal;
    logic        exp_valid;
    logic [31:0] last_word;

    // Set while the previous transfer's ack is still on the bus
    logic        ack_outstanding = 1'b0;

    logic [31:0] lfsr_state = 32'd21;
    logic [6:0]  legal_ops [0:10] = '{`RV_OP_LUI, `RV_OP_AUIPC, `RV_OP_JAL, `RV_OP_JALR,
                                      `RV_OP_BRANCH, `RV_OP_LOAD, `RV_OP_STORE, `RV_OP_IMM,
                                      `RV_OP_OP, `RV_OP_FENCE, `RV_OP_SYSTEM};

    int errors = 0;
    int errors_at_start = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_count = 0;

    rv_decode_top dut_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack        (wb_ack),
        .op_class      (op_class),
        .format        (format),
        .rd            (rd),
        .rs1           (rs1),
        .rs2           (rs2),
        .funct3        (funct3),
        .funct7        (funct7),
        .shamt         (shamt),
        .imm           (imm),
        .rd_we         (rd_we),
        .illegal       (illegal),
        .decoded_valid (decoded_valid)
    );

    always #10 clock = ~clock;

    always @(posedge clock)
    begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit handed out
    function automatic logic rand_bit();
        if (lfsr_state[0])
            lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
        else
            lfsr_state = lfsr_state >> 1;
        return lfsr_state[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[30:0], rand_bit()};
        return r;
    endfunction

    function automatic rv_class_e class_of(input logic [6:0] opc);
        case (opc)
            `RV_OP_LUI:    class_of = CLS_LUI;
            `RV_OP_AUIPC:  class_of = CLS_AUIPC;
            `RV_OP_JAL:    class_of = CLS_JAL;
            `RV_OP_JALR:   class_of = CLS_JALR;
            `RV_OP_BRANCH: class_of = CLS_BRANCH;
            `RV_OP_LOAD:   class_of = CLS_LOAD;
            `RV_OP_STORE:  class_of = CLS_STORE;
            `RV_OP_IMM:    class_of = CLS_OP_IMM;
            `RV_OP_OP:     class_of = CLS_OP;
            `RV_OP_FENCE:  class_of = CLS_FENCE;
            `RV_OP_SYSTEM: class_of = CLS_SYSTEM;
            default:       class_of = CLS_ILLEGAL;
        endcase
    endfunction

    function automatic rv_format_e format_of(input rv_class_e cls);
        case (cls)
            CLS_LUI, CLS_AUIPC: format_of = FMT_U;
            CLS_JAL:            format_of = FMT_J;
            CLS_BRANCH:         format_of = FMT_B;
            CLS_STORE:          format_of = FMT_S;
            CLS_OP:             format_of = FMT_R;
            CLS_ILLEGAL:        format_of = FMT_NONE;
            default:            format_of = FMT_I;
        endcase
    endfunction

    // All listed opcodes end in 11, so unknown and compressed words both fall to default
    function automatic logic is_legal(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[6:0])
            `RV_OP_LUI, `RV_OP_AUIPC, `RV_OP_JAL, `RV_OP_FENCE, `RV_OP_SYSTEM:
                is_legal = 1'b1;
            `RV_OP_JALR:   is_legal = (f3 == 3'b000);
            `RV_OP_BRANCH: is_legal = (f3 != 3'b010) && (f3 != 3'b011);
            `RV_OP_LOAD:   is_legal = (f3 != 3'b011) && (f3 != 3'b110) && (f3 != 3'b111);
            `RV_OP_STORE:  is_legal = (f3 <= 3'b010);
            `RV_OP_IMM:
                if (f3 == 3'b001)
                    is_legal = (f7 == 7'h00);
                else if (f3 == 3'b101)
                    is_legal = (f7 == 7'h00) || (f7 == 7'h20);
                else
                    is_legal = 1'b1;
            `RV_OP_OP:
                is_legal = (f7 == 7'h00)
                           || ((f7 == 7'h20) && ((f3 == 3'b000) || (f3 == 3'b101)));
            default:       is_legal = 1'b0;
        endcase
    endfunction

    // Reference decode of one written word into the exp_ variables
    task automatic model_decode(input logic [31:0] w);
        rv_class_e  cls;
        rv_format_e fmt;
        logic       shift;
        logic       no_regs;
        logic       use_rd;
        logic       use_rs1;
        logic       use_rs2;
        cls     = is_legal(w) ? class_of(w[6:0]) : CLS_ILLEGAL;
        fmt     = format_of(cls);
        shift   = (cls == CLS_OP_IMM) && (w[13:12] == 2'b01);
        no_regs = (cls == CLS_FENCE) || (cls == CLS_SYSTEM);
        use_rd  = (fmt == FMT_R) || (fmt == FMT_U) || (fmt == FMT_J)
                  || ((fmt == FMT_I) && !no_regs);
        use_rs1 = (fmt == FMT_R) || (fmt == FMT_S) || (fmt == FMT_B)
                  || ((fmt == FMT_I) && !no_regs);
        use_rs2 = (fmt == FMT_R) || (fmt == FMT_S) || (fmt == FMT_B);
        case (fmt)
            FMT_I:   exp_imm = shift ? {27'b0, w[24:20]} : {{20{w[31]}}, w[31:20]};
            FMT_S:   exp_imm = {{20{w[31]}}, w[31:25], w[11:7]};
            FMT_B:   exp_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            FMT_U:   exp_imm = {w[31:12], 12'b0};
            FMT_J:   exp_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: exp_imm = 32'b0;
        endcase
        exp_class   = cls;
        exp_fmt     = fmt;
        exp_rd      = use_rd ? w[11:7] : 5'd0;
        exp_rs1     = use_rs1 ? w[19:15] : 5'd0;
        exp_rs2     = use_rs2 ? w[24:20] : 5'd0;
        exp_f3      = ((fmt == FMT_U) || (fmt == FMT_J) || (fmt == FMT_NONE)) ? 3'd0 : w[14:12];
        exp_f7      = ((fmt == FMT_R) || shift) ? w[31:25] : 7'd0;
        exp_shamt   = shift ? w[24:20] : 5'd0;
        exp_rd_we   = use_rd && (w[11:7] != 5'd0);
        exp_illegal = (cls == CLS_ILLEGAL);
        exp_valid   = 1'b1;
    endtask

    task automatic clear_expected();
        exp_class   = rv_class_e'(4'd0);
        exp_fmt     = rv_format_e'(3'd0);
        exp_rd      = '0;
        exp_rs1     = '0;
        exp_rs2     = '0;
        exp_f3      = '0;
        exp_f7      = '0;
        exp_shamt   = '0;
        exp_imm     = '0;
        exp_rd_we   = 1'b0;
        exp_illegal = 1'b0;
        exp_valid   = 1'b0;
    endtask

    // Legal opcode with random fields that are redrawn until the funct rules pass
    function automatic logic [31:0] legal_word();
        logic [31:0] w;
        logic [6:0]  opc;
        opc = legal_ops[rand_bits(4) % 11];
        do
        begin
            w = rand_bits(32);
            w[6:0] = opc;
            if ((opc == `RV_OP_OP) || ((opc == `RV_OP_IMM) && (w[13:12] == 2'b01)))
                w[31:25] = {1'b0, rand_bit(), 5'b0};
        end
        while (!is_legal(w));
        return w;
    endfunction

    // Bad low bits, unknown opcode or a forbidden funct combination
    function automatic logic [31:0] illegal_word();
        logic [31:0] w;
        logic [31:0] kind;
        kind = rand_bits(2) % 3;
        w = rand_bits(32);
        if (kind == 0)
            w[1:0] = rand_bit() ? 2'b01 : {rand_bit(), 1'b0};
        else if (kind == 1)
        begin
            w[1:0] = 2'b11;
            while (class_of(w[6:0]) != CLS_ILLEGAL)
                w[6:2] = 5'(rand_bits(5));
        end
        else
        begin
            w[6:0] = legal_ops[rand_bits(4) % 11];
            while (is_legal(w))
            begin
                w = rand_bits(32);
                w[6:0] = legal_ops[rand_bits(4) % 11];
            end
        end
        return w;
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s for word %08h, got %0h, expected %0h",
                     $time, what, last_word, actual, expected);
            errors++;
        end
    endtask

    task automatic check_outputs();
        check(32'(op_class), 32'(exp_class), "op_class");
        check(32'(format), 32'(exp_fmt), "format");
        check(32'(rd), 32'(exp_rd), "rd");
        check(32'(rs1), 32'(exp_rs1), "rs1");
        check(32'(rs2), 32'(exp_rs2), "rs2");
        check(32'(funct3), 32'(exp_f3), "funct3");
        check(32'(funct7), 32'(exp_f7), "funct7");
        check(32'(shamt), 32'(exp_shamt), "shamt");
        check(imm, exp_imm, "imm");
        check(32'(rd_we), 32'(exp_rd_we), "rd_we");
        check(32'(illegal), 32'(exp_illegal), "illegal");
        check(32'(decoded_valid), 32'(exp_valid), "decoded_valid");
    endtask

    // One Wishbone transfer that starts and ends on a falling edge with wb_stb still high
    task automatic bus_cycle(input logic we, input logic [31:0] data);
        int waited;
        int exp_lat;
        // A strobe that meets the previous ack is only accepted one cycle later
        exp_lat  = ack_outstanding ? 2 : 1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_dat_i = data;
        waited   = 0;
        do
        begin
            @(negedge clock);
            waited++;
        end
        while (!wb_ack && (waited < 6));
        if (!wb_ack)
        begin
            $display("ERROR at %0t: the DUT never acknowledged the bus cycle", $time);
            errors++;
        end
        else
            check(waited, exp_lat, "acknowledge latency");
        ack_outstanding = 1'b1;
        if (we)
        begin
            last_word = data;
            model_decode(data);
        end
        check_outputs();
        check(wb_dat_o, exp_imm, "read data");
    endtask

    // Strobe low with junk on the other inputs while the outputs must hold
    task automatic idle_cycles(input int n);
        wb_stb   = 1'b0;
        wb_cyc   = rand_bit();
        wb_we    = rand_bit();
        wb_dat_i = rand_bits(32);
        ack_outstanding = 1'b0;
        repeat (n)
        begin
            @(negedge clock);
            check(32'(wb_ack), 0, "acknowledge while idle");
            check_outputs();
        end
    endtask

    task automatic start_test();
        errors_at_start = errors;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errors_at_start)
            $display("[%0t] %s: ok", $time, name);
        else
        begin
            tests_failed++;
            $display("[%0t] %s: FAILED with %0d errors", $time, name, errors - errors_at_start);
        end
    endtask

    initial
    begin
        logic [31:0] w;
        int          gap;
        rst_n     = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_dat_i  = '0;
        last_word = '0;
        clear_expected();
        repeat (8) @(negedge clock);
        rst_n = 1'b1;

        start_test();
        check(32'(wb_ack), 0, "acknowledge after reset");
        check_outputs();
        idle_cycles(IDLE_CYCLES);
        finish_test("reset and idle");

        start_test();
        repeat (N_LEGAL)
            bus_cycle(1'b1, legal_word());
        finish_test("random legal words");

        start_test();
        repeat (N_ILLEGAL)
        begin
            bus_cycle(1'b1, illegal_word());
            check(32'(illegal), 1, "illegal flag");
            check(32'(op_class), 32'(CLS_ILLEGAL), "illegal class");
        end
        finish_test("illegal words");

        start_test();
        repeat (N_SHIFT)
        begin
            w = rand_bits(32);
            w[6:0] = `RV_OP_IMM;
            w[13:12] = 2'b01;
            w[31:25] = w[14] ? {1'b0, rand_bit(), 5'b0} : 7'b0;
            bus_cycle(1'b1, w);
            check(32'(shamt), 32'(w[24:20]), "shift amount");
            check(imm, 32'(w[24:20]), "shift immediate");
        end
        // SRAI encoding is legal but the same funct7 on SLLI is not
        w = rand_bits(32);
        w[31:25] = 7'h20;
        w[14:12] = 3'b101;
        w[6:0] = `RV_OP_IMM;
        bus_cycle(1'b1, w);
        check(32'(illegal), 0, "funct7 0100000 with funct3 101");
        w[14:12] = 3'b001;
        bus_cycle(1'b1, w);
        check(32'(illegal), 1, "funct7 0100000 with funct3 001");
        finish_test("shift immediates");

        start_test();
        repeat (N_READ)
        begin
            bus_cycle(1'b1, legal_word());
            bus_cycle(1'b0, rand_bits(32));
            idle_cycles(1);
        end
        finish_test("read back");

        start_test();
        repeat (N_B2B)
            bus_cycle(1'b1, legal_word());
        repeat (N_GAP)
        begin
            if (rand_bit())
                w = legal_word();
            else
                w = illegal_word();
            bus_cycle(1'b1, w);
            gap = int'(rand_bits(2));
            if (gap > 0)
                idle_cycles(gap);
        end
        idle_cycles(1);
        finish_test("back-to-back and gaps");

        $display("Tests run: %0d, tests failed: %0d, failed checks: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule
